/* files.f */
spi_host_pkg.sv
spi_host_fifo.sv
spi_host_shift_register.sv
spi_host_fsm.sv
spi_host_core.sv
tb_clk_gen.sv
tb_spi_host.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI host testbench with Verilator.
# Exits 0 only when the run prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_spi_host -f files.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vtb_spi_host)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx 'STATUS: PASS'; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* spi_host_core.sv */
// SPI host top level: command and transmit queues feeding the sequencer and the shift register
`timescale 1ns/1ns

module spi_host_core (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 sw_rst_i,
  input  logic                 cmd_valid_i,
  output logic                 cmd_ready_o,
  input  spi_host_pkg::speed_e cmd_speed_i,
  input  logic [7:0]           cmd_len_i,
  input  logic                 cmd_tx_en_i,
  input  logic                 cmd_rx_en_i,
  input  logic                 cmd_full_cyc_i,
  input  logic [7:0]           tx_data_i,
  input  logic                 tx_valid_i,
  output logic                 tx_ready_o,
  output logic [7:0]           rx_data_o,
  output logic                 rx_last_o,
  output logic                 rx_valid_o,
  input  logic                 rx_ready_i,
  output logic                 sck_o,
  output logic                 csb_o,
  output logic [3:0]           sd_o,
  output logic [3:0]           sd_en_o,
  input  logic [3:0]           sd_i,
  output logic                 active_o
);

  spi_host_pkg::cmd_t   cmd_in;
  spi_host_pkg::cmd_t   cmd_out;
  logic                 cmd_out_valid;
  logic                 cmd_out_ready;
  logic [7:0]           txq_data;
  logic                 txq_valid;
  logic                 txq_ready;
  logic                 wr_en;
  logic                 wr_ready;
  logic                 rd_en;
  logic                 rd_ready;
  logic                 shift_en;
  logic                 sample_en;
  logic                 full_cyc;
  logic                 last_read;
  spi_host_pkg::speed_e speed;

  assign cmd_in.speed    = cmd_speed_i;
  assign cmd_in.len      = cmd_len_i;
  assign cmd_in.tx_en    = cmd_tx_en_i;
  assign cmd_in.rx_en    = cmd_rx_en_i;
  assign cmd_in.full_cyc = cmd_full_cyc_i;

  spi_host_fifo #(
    .payload_t (spi_host_pkg::cmd_t),
    .Depth     (spi_host_pkg::CmdDepth)
  ) cmd_fifo_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .sw_rst_i    (sw_rst_i),
    .in_data_i   (cmd_in),
    .in_valid_i  (cmd_valid_i),
    .in_ready_o  (cmd_ready_o),
    .out_data_o  (cmd_out),
    .out_valid_o (cmd_out_valid),
    .out_ready_i (cmd_out_ready)
  );

  spi_host_fifo #(
    .payload_t (logic [7:0]),
    .Depth     (spi_host_pkg::TxDepth)
  ) tx_fifo_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .sw_rst_i    (sw_rst_i),
    .in_data_i   (tx_data_i),
    .in_valid_i  (tx_valid_i),
    .in_ready_o  (tx_ready_o),
    .out_data_o  (txq_data),
    .out_valid_o (txq_valid),
    .out_ready_i (txq_ready)
  );

  spi_host_fsm fsm_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .sw_rst_i    (sw_rst_i),
    .cmd_i       (cmd_out),
    .cmd_valid_i (cmd_out_valid),
    .cmd_ready_o (cmd_out_ready),
    .sck_o       (sck_o),
    .csb_o       (csb_o),
    .sd_en_o     (sd_en_o),
    .active_o    (active_o),
    .wr_en_o     (wr_en),
    .wr_ready_i  (wr_ready),
    .rd_en_o     (rd_en),
    .rd_ready_i  (rd_ready),
    .shift_en_o  (shift_en),
    .sample_en_o (sample_en),
    .full_cyc_o  (full_cyc),
    .last_read_o (last_read),
    .speed_o     (speed)
  );

  spi_host_shift_register shift_reg_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .sw_rst_i    (sw_rst_i),
    .wr_en_i     (wr_en),
    .wr_ready_o  (wr_ready),
    .rd_en_i     (rd_en),
    .rd_ready_o  (rd_ready),
    .speed_i     (speed),
    .shift_en_i  (shift_en),
    .sample_en_i (sample_en),
    .full_cyc_i  (full_cyc),
    .last_read_i (last_read),
    .tx_data_i   (txq_data),
    .tx_valid_i  (txq_valid),
    .tx_ready_o  (txq_ready),
    .rx_data_o   (rx_data_o),
    .rx_valid_o  (rx_valid_o),
    .rx_ready_i  (rx_ready_i),
    .rx_last_o   (rx_last_o),
    .sd_i        (sd_i),
    .sd_o        (sd_o)
  );

endmodule

/* spi_host_fifo.sv */
// Small synchronous FIFO with valid/ready on both sides, used for commands and transmit bytes
`timescale 1ns/1ns

module spi_host_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  Depth     = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     sw_rst_i,
  input  payload_t in_data_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output payload_t out_data_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic [CntW-1:0] count_d;
  logic            ready_q;
  logic            push;
  logic            pop;

  // pointers wrap at Depth, which need not be a power of two
  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    next_ptr = (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push        = in_valid_i && ready_q;
  assign pop         = out_valid_o && out_ready_i;
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  // ready is registered, so it stays low while reset is held
  assign in_ready_o  = ready_q;

  always_comb begin
    count_d = count_q;
    if (push && !pop) begin
      count_d = count_q + 1'b1;
    end else if (pop && !push) begin
      count_d = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ready_q  <= 1'b0;
    end else if (sw_rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ready_q  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_d;
      ready_q <= (count_d != CntW'(Depth));
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

endmodule

/* spi_host_fsm.sv */
// SPI host sequencer: runs one command at a time, drives sck and csb, strobes the shift register
`timescale 1ns/1ns

module spi_host_fsm (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 sw_rst_i,
  input  spi_host_pkg::cmd_t   cmd_i,
  input  logic                 cmd_valid_i,
  output logic                 cmd_ready_o,
  output logic                 sck_o,
  output logic                 csb_o,
  output logic [3:0]           sd_en_o,
  output logic                 active_o,
  output logic                 wr_en_o,
  input  logic                 wr_ready_i,
  output logic                 rd_en_o,
  input  logic                 rd_ready_i,
  output logic                 shift_en_o,
  output logic                 sample_en_o,
  output logic                 full_cyc_o,
  output logic                 last_read_o,
  output spi_host_pkg::speed_e speed_o
);

  typedef enum logic [1:0] {
    Idle,
    CsSetup,
    Clocking,
    CsHold
  } state_e;

  state_e                          state_q;
  state_e                          state_d;
  spi_host_pkg::cmd_t              cmd_q;
  logic [spi_host_pkg::DivCntW-1:0] div_q;
  logic [spi_host_pkg::DivCntW-1:0] div_d;
  logic [2:0]                      bit_q;
  logic [2:0]                      bit_d;
  logic [7:0]                      byte_q;
  logic [7:0]                      byte_d;
  logic                            sck_q;
  logic                            sck_d;
  logic                            csb_q;
  logic                            csb_d;
  logic                            tick;
  logic                            last_bit;
  logic                            last_byte;
  logic                            fall_edge;
  logic                            byte_end;
  logic                            stall;

  assign tick      = (div_q == spi_host_pkg::DivCntW'(spi_host_pkg::ClkDiv - 1));
  assign last_byte = (byte_q == 8'd0);

  // bit periods per byte: 8, 4 or 2
  always_comb begin
    case (cmd_q.speed)
      spi_host_pkg::Dual: last_bit = (bit_q == 3'd3);
      spi_host_pkg::Quad: last_bit = (bit_q == 3'd1);
      default:            last_bit = (bit_q == 3'd7);
    endcase
  end

  assign fall_edge = (state_q == Clocking) && tick && sck_q;
  assign byte_end  = fall_edge && last_bit;

  // hold sck when the next byte is missing or the rx buffer is still full
  assign stall = byte_end &&
                 ((cmd_q.rx_en && !rd_ready_i) ||
                  (!last_byte && cmd_q.tx_en && !wr_ready_i));

  assign cmd_ready_o = (state_q == Idle);
  assign active_o    = (state_q != Idle);
  assign sck_o       = sck_q;
  assign csb_o       = csb_q;
  assign speed_o     = cmd_q.speed;
  assign full_cyc_o  = cmd_q.full_cyc;
  assign last_read_o = last_byte;

  // first byte loads in setup, later ones on the last falling edge of the byte before
  assign wr_en_o     = cmd_q.tx_en &&
                       (((state_q == CsSetup) && wr_ready_i) ||
                        (byte_end && !last_byte && !stall));
  assign rd_en_o     = cmd_q.rx_en && byte_end && !stall;
  assign shift_en_o  = fall_edge && !stall;
  assign sample_en_o = (state_q == Clocking) && tick && !sck_q;

  always_comb begin
    sd_en_o = 4'h0;
    if (state_q != Idle && cmd_q.tx_en) begin
      case (cmd_q.speed)
        spi_host_pkg::Dual: sd_en_o = 4'h3;
        spi_host_pkg::Quad: sd_en_o = 4'hf;
        default:            sd_en_o = 4'h1;
      endcase
    end
  end

  always_comb begin
    state_d = state_q;
    div_d   = div_q;
    bit_d   = bit_q;
    byte_d  = byte_q;
    sck_d   = sck_q;
    csb_d   = csb_q;
    case (state_q)
      Idle: begin
        if (cmd_valid_i) begin
          state_d = CsSetup;
          csb_d   = 1'b0;
          byte_d  = cmd_i.len;
          bit_d   = 3'd0;
          div_d   = '0;
        end
      end
      CsSetup: begin
        // wait here until the first transmit byte is there
        if (!cmd_q.tx_en || wr_ready_i) begin
          state_d = Clocking;
          div_d   = '0;
        end
      end
      Clocking: begin
        if (!stall) begin
          div_d = tick ? '0 : div_q + 1'b1;
          if (tick) begin
            sck_d = !sck_q;
          end
          if (fall_edge) begin
            bit_d = last_bit ? 3'd0 : bit_q + 1'b1;
            if (last_bit) begin
              if (last_byte) begin
                state_d = CsHold;
              end else begin
                byte_d = byte_q - 1'b1;
              end
            end
          end
        end
      end
      CsHold: begin
        div_d = tick ? '0 : div_q + 1'b1;
        if (tick) begin
          csb_d   = 1'b1;
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      div_q   <= '0;
      bit_q   <= 3'd0;
      byte_q  <= 8'd0;
      sck_q   <= 1'b0;
      csb_q   <= 1'b1;
    end else if (sw_rst_i) begin
      state_q <= Idle;
      div_q   <= '0;
      bit_q   <= 3'd0;
      byte_q  <= 8'd0;
      sck_q   <= 1'b0;
      csb_q   <= 1'b1;
    end else begin
      state_q <= state_d;
      div_q   <= div_d;
      bit_q   <= bit_d;
      byte_q  <= byte_d;
      sck_q   <= sck_d;
      csb_q   <= csb_d;
    end
  end

  // command is held for the whole transfer
  always_ff @(posedge clk_i) begin
    if (cmd_valid_i && cmd_ready_o) begin
      cmd_q <= cmd_i;
    end
  end

endmodule

/* spi_host_pkg.sv */
// Shared SPI host definitions: lane speeds, the command payload, divider and FIFO depths
package spi_host_pkg;

  // lane speed of a command
  // the reserved code is handled as standard (single lane)
  typedef enum logic [1:0] {
    Standard = 2'b00,
    Dual     = 2'b01,
    Quad     = 2'b10,
    RsvdSpd  = 2'b11
  } speed_e;

  // one queued SPI command
  typedef struct packed {
    speed_e     speed;
    // byte count minus one
    logic [7:0] len;
    logic       tx_en;
    logic       rx_en;
    // take the sampled input at the falling edge instead of the rising one
    logic       full_cyc;
  } cmd_t;

  // system clocks per half period of the serial clock
  localparam int ClkDiv = 2;

  // width of the divider counter
  localparam int DivCntW = (ClkDiv > 1) ? $clog2(ClkDiv) : 1;

  // queue depths
  localparam int CmdDepth = 2;
  localparam int TxDepth  = 4;

endpackage

/* spi_host_shift_register.sv */
// Byte shift register of the SPI host: lane shifting, input sampling and a one-entry rx buffer
`timescale 1ns/1ns

module spi_host_shift_register (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 sw_rst_i,
  input  logic                 wr_en_i,
  output logic                 wr_ready_o,
  input  logic                 rd_en_i,
  output logic                 rd_ready_o,
  input  spi_host_pkg::speed_e speed_i,
  input  logic                 shift_en_i,
  input  logic                 sample_en_i,
  input  logic                 full_cyc_i,
  input  logic                 last_read_i,
  input  logic [7:0]           tx_data_i,
  input  logic                 tx_valid_i,
  output logic                 tx_ready_o,
  output logic [7:0]           rx_data_o,
  output logic                 rx_valid_o,
  input  logic                 rx_ready_i,
  output logic                 rx_last_o,
  input  logic [3:0]           sd_i,
  output logic [3:0]           sd_o
);

  logic [7:0] sr_q;
  logic [7:0] sr_shifted;
  logic [3:0] sd_q;
  logic [3:0] next_bits;
  logic [7:0] rx_buf_q;
  logic       rx_last_q;
  logic       rx_valid_q;
  logic       capture;

  // full-cycle mode takes the live lanes at the falling edge,
  // otherwise the value held since the rising edge
  assign next_bits = full_cyc_i ? sd_i : sd_q;

  // standard mode receives on lane 1 and sends on lane 0
  always_comb begin
    case (speed_i)
      spi_host_pkg::Dual: begin
        sr_shifted = {sr_q[5:0], next_bits[1:0]};
        sd_o       = {2'b00, sr_q[7:6]};
      end
      spi_host_pkg::Quad: begin
        sr_shifted = {sr_q[3:0], next_bits[3:0]};
        sd_o       = sr_q[7:4];
      end
      default: begin
        sr_shifted = {sr_q[6:0], next_bits[1]};
        sd_o       = {3'b000, sr_q[7]};
      end
    endcase
  end

  // the transmit byte is used straight from the FIFO head
  assign wr_ready_o = tx_valid_i;
  assign tx_ready_o = wr_en_i && tx_valid_i;

  // buffer may drain and refill in the same cycle
  assign rd_ready_o = !rx_valid_q || rx_ready_i;
  assign capture    = rd_en_i && rd_ready_o;

  assign rx_valid_o = rx_valid_q;
  assign rx_data_o  = rx_buf_q;
  assign rx_last_o  = rx_last_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sd_q       <= 4'h0;
      sr_q       <= 8'h00;
      rx_valid_q <= 1'b0;
    end else if (sw_rst_i) begin
      sd_q       <= 4'h0;
      sr_q       <= 8'h00;
      rx_valid_q <= 1'b0;
    end else begin
      if (sample_en_i) begin
        sd_q <= sd_i;
      end
      // a load wins over the last shift of the previous byte
      if (wr_en_i && wr_ready_o) begin
        sr_q <= tx_data_i;
      end else if (shift_en_i) begin
        sr_q <= sr_shifted;
      end
      if (capture) begin
        rx_valid_q <= 1'b1;
      end else if (rx_ready_i) begin
        rx_valid_q <= 1'b0;
      end
    end
  end

  // captured byte includes the shift of the same cycle
  always_ff @(posedge clk_i) begin
    if (capture) begin
      rx_buf_q  <= sr_shifted;
      rx_last_q <= last_read_i;
    end
  end

endmodule

/* tb_clk_gen.sv */
// Testbench clock and reset source for the SPI host testbench: 20 ns clock, reset held two cycles
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    // release a little after the edge, like every other driven input
    #2;
    rst_no = 1'b1;
  end

  always #10 clk_o = ~clk_o;

endmodule

/* tb_spi_host.sv */
// Testbench top for the SPI host: serial device model, random commands, checks against a model
`timescale 1ns/1ns

module tb_spi_host;

  localparam int NumStd    = 6;
  localparam int NumRx     = 8;
  localparam int NumDuplex = 12;
  localparam int NumStress = 10;
  localparam int NumCmds   = NumStd + NumRx + NumDuplex + NumStress + 2;
  // worst case per command is 256 bytes of 16 half periods
  localparam longint TimeLimit =
    longint'(NumCmds) * 256 * 16 * spi_host_pkg::ClkDiv * 20 + 20000;

  logic                 clk;
  logic                 rst_n;
  logic                 sw_rst;
  logic                 cmd_valid;
  logic                 cmd_ready;
  spi_host_pkg::speed_e cmd_speed;
  logic [7:0]           cmd_len;
  logic                 cmd_tx_en;
  logic                 cmd_rx_en;
  logic                 cmd_full_cyc;
  logic [7:0]           tx_data;
  logic                 tx_valid;
  logic                 tx_ready;
  logic [7:0]           rx_data;
  logic                 rx_last;
  logic                 rx_valid;
  logic                 rx_ready;
  logic                 sck;
  logic                 csb;
  logic [3:0]           sd_out;
  logic [3:0]           sd_en;
  logic [3:0]           sd_in;
  logic                 active;

  // model queues
  logic [7:0] tx_send_q[$];
  logic [7:0] exp_tx_q[$];
  logic [7:0] exp_rx_q[$];
  logic       exp_last_q[$];
  logic [7:0] resp_q[$];
  int         dev_lanes_q[$];
  int         dev_len_q[$];
  logic       dev_tx_en_q[$];

  // device and monitor state
  int         rx_ready_pct;
  int         dev_lanes;
  int         dev_pos;
  int         dev_bytes_left;
  int         tx_groups;
  logic       dev_tx_en;
  logic       dev_busy;
  logic [7:0] resp_cur;
  logic [7:0] tx_acc;
  int         run_len;
  logic       sck_prev;
  logic       first_low;

  tb_clk_gen clk_gen_i (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  spi_host_core spi_host_core_i (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .sw_rst_i       (sw_rst),
    .cmd_valid_i    (cmd_valid),
    .cmd_ready_o    (cmd_ready),
    .cmd_speed_i    (cmd_speed),
    .cmd_len_i      (cmd_len),
    .cmd_tx_en_i    (cmd_tx_en),
    .cmd_rx_en_i    (cmd_rx_en),
    .cmd_full_cyc_i (cmd_full_cyc),
    .tx_data_i      (tx_data),
    .tx_valid_i     (tx_valid),
    .tx_ready_o     (tx_ready),
    .rx_data_o      (rx_data),
    .rx_last_o      (rx_last),
    .rx_valid_o     (rx_valid),
    .rx_ready_i     (rx_ready),
    .sck_o          (sck),
    .csb_o          (csb),
    .sd_o           (sd_out),
    .sd_en_o        (sd_en),
    .sd_i           (sd_in),
    .active_o       (active)
  );

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      stop_on_failure($sformatf("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                                $time, what, actual, expected));
    end
  endtask

  function automatic int lanes_of(input spi_host_pkg::speed_e speed);
    case (speed)
      spi_host_pkg::Dual: lanes_of = 2;
      spi_host_pkg::Quad: lanes_of = 4;
      default:            lanes_of = 1;
    endcase
  endfunction

  function automatic logic [3:0] lane_mask(input int lanes);
    lane_mask = (lanes == 4) ? 4'hf : ((lanes == 2) ? 4'h3 : 4'h1);
  endfunction

  // response bits for one bit period, MSB first; standard mode answers on lane 1
  function automatic logic [3:0] lane_bits(input logic [7:0] b, input int lanes, input int pos);
    logic [7:0] s;
    s = b << (pos * lanes);
    if (lanes == 4) begin
      lane_bits = s[7:4];
    end else if (lanes == 2) begin
      lane_bits = {2'b00, s[7:6]};
    end else begin
      lane_bits = {2'b00, s[7], 1'b0};
    end
  endfunction

  task automatic wait_drive_slot();
    @(posedge clk);
    #2;
  endtask

  task automatic check_idle(input string when);
    check_value(csb, 1'b1, {"csb_o ", when});
    check_value(sck, 1'b0, {"sck_o ", when});
    check_value(rx_valid, 1'b0, {"rx_valid_o ", when});
    check_value(active, 1'b0, {"active_o ", when});
    check_value(sd_en, 4'h0, {"sd_en_o ", when});
  endtask

  task automatic prepare_command(input spi_host_pkg::speed_e speed, input logic [7:0] len,
                                 input logic tx_en, input logic rx_en);
    int         i;
    logic [7:0] b;
    for (i = 0; i <= int'(len); i++) begin
      b = 8'($urandom);
      resp_q.push_back(b);
      if (rx_en) begin
        exp_rx_q.push_back(b);
        exp_last_q.push_back(i == int'(len));
      end
      if (tx_en) begin
        b = 8'($urandom);
        tx_send_q.push_back(b);
        exp_tx_q.push_back(b);
      end
    end
    dev_lanes_q.push_back(lanes_of(speed));
    dev_len_q.push_back(int'(len));
    dev_tx_en_q.push_back(tx_en);
  endtask

  task automatic send_command(input spi_host_pkg::speed_e speed, input logic [7:0] len,
                              input logic tx_en, input logic rx_en, input logic full_cyc);
    cmd_speed    = speed;
    cmd_len      = len;
    cmd_tx_en    = tx_en;
    cmd_rx_en    = rx_en;
    cmd_full_cyc = full_cyc;
    cmd_valid    = 1'b1;
    do @(negedge clk); while (!cmd_ready);
    wait_drive_slot();
    cmd_valid = 1'b0;
  endtask

  task automatic send_tx_bytes(input int max_gap);
    int gap;
    while (tx_send_q.size() != 0) begin
      gap = $urandom_range(max_gap, 0);
      repeat (gap) wait_drive_slot();
      tx_data  = tx_send_q.pop_front();
      tx_valid = 1'b1;
      do @(negedge clk); while (!tx_ready);
      wait_drive_slot();
      tx_valid = 1'b0;
    end
  endtask

  task automatic run_command(input spi_host_pkg::speed_e speed, input logic [7:0] len,
                             input logic tx_en, input logic rx_en, input logic full_cyc,
                             input int max_gap);
    prepare_command(speed, len, tx_en, rx_en);
    fork
      send_command(speed, len, tx_en, rx_en, full_cyc);
      send_tx_bytes(max_gap);
    join
    // done once the device has seen the whole command and all rx bytes left
    do @(negedge clk);
    while (dev_lanes_q.size() != 0 || dev_busy || exp_tx_q.size() != 0 ||
           exp_rx_q.size() != 0 || active);
    wait_drive_slot();
  endtask

  task automatic abort_with_sw_reset();
    prepare_command(spi_host_pkg::Standard, 8'd7, 1'b0, 1'b1);
    send_command(spi_host_pkg::Standard, 8'd7, 1'b0, 1'b1, 1'b0);
    repeat (20) @(posedge sck);
    wait_drive_slot();
    sw_rst = 1'b1;
    wait_drive_slot();
    check_idle("after software reset");
    sw_rst = 1'b0;
    exp_tx_q.delete();
    exp_rx_q.delete();
    exp_last_q.delete();
    resp_q.delete();
    dev_lanes_q.delete();
    dev_len_q.delete();
    dev_tx_en_q.delete();
    dev_busy = 1'b0;
    wait_drive_slot();
  endtask

  // device: a new command starts when csb falls
  always @(negedge csb) begin
    if (dev_lanes_q.size() == 0) begin
      stop_on_failure($sformatf("chip select fell at %0t ns with no command pending", $time));
    end else begin
      dev_lanes      = dev_lanes_q.pop_front();
      dev_bytes_left = dev_len_q.pop_front() + 1;
      dev_tx_en      = dev_tx_en_q.pop_front();
      dev_busy       = 1'b1;
      dev_pos        = 0;
      tx_groups      = 0;
      tx_acc         = 8'h00;
      resp_cur       = resp_q.pop_front();
      #2;
      sd_in = lane_bits(resp_cur, dev_lanes, 0);
    end
  end

  always @(posedge csb) begin
    dev_busy = 1'b0;
  end

  // device collects transmit lanes on rising sck
  always @(posedge sck) begin
    if (dev_busy) begin
      check_value(sd_en, dev_tx_en ? lane_mask(dev_lanes) : 4'h0, "sd_en_o");
      if (dev_tx_en) begin
        tx_acc    = (tx_acc << dev_lanes) | {4'h0, sd_out & lane_mask(dev_lanes)};
        tx_groups = tx_groups + 1;
        if (tx_groups == 8 / dev_lanes) begin
          tx_groups = 0;
          if (exp_tx_q.size() == 0) begin
            stop_on_failure($sformatf("device got an extra transmit byte at %0t ns", $time));
          end else begin
            check_value(tx_acc, exp_tx_q.pop_front(), "transmit byte seen by device");
          end
        end
      end
    end
  end

  // device moves to the next response bits after falling sck
  always @(negedge sck) begin
    if (dev_busy) begin
      dev_pos = dev_pos + 1;
      if (dev_pos == 8 / dev_lanes) begin
        dev_pos        = 0;
        dev_bytes_left = dev_bytes_left - 1;
        resp_cur       = (dev_bytes_left > 0 && resp_q.size() != 0) ? resp_q.pop_front() : 8'h00;
      end
      #2;
      sd_in = lane_bits(resp_cur, dev_lanes, dev_pos);
    end
  end

  always @(posedge clk) begin
    #2;
    rx_ready = ($urandom_range(99, 0) < rx_ready_pct);
  end

  // receive stream, sampled mid-cycle where valid and ready are stable
  always @(negedge clk) begin
    if (rst_n && !sw_rst && rx_valid) begin
      if (exp_rx_q.size() == 0) begin
        stop_on_failure($sformatf("unexpected receive byte 0x%0h at %0t ns", rx_data, $time));
      end else if (rx_ready) begin
        check_value(rx_data, exp_rx_q.pop_front(), "rx_data_o");
        check_value(rx_last, exp_last_q.pop_front(), "rx_last_o");
      end
    end
  end

  // sck half periods: a long high phase is only allowed at a byte boundary (stall)
  always @(negedge clk) begin
    if (!rst_n || sw_rst || csb) begin
      run_len   = 0;
      sck_prev  = sck;
      first_low = 1'b1;
    end else if (sck == sck_prev) begin
      run_len = run_len + 1;
    end else begin
      if (!sck_prev && !first_low) begin
        check_value(run_len, spi_host_pkg::ClkDiv, "sck low phase in clocks");
      end
      if (sck_prev && dev_pos != 0) begin
        check_value(run_len, spi_host_pkg::ClkDiv, "sck high phase inside a byte");
      end
      if (!sck_prev) begin
        first_low = 1'b0;
      end
      sck_prev = sck;
      run_len  = 1;
    end
  end

  initial begin
    #(TimeLimit);
    stop_on_failure($sformatf("timeout at %0t ns, the commands did not complete", $time));
  end

  initial begin
    int                   seed_ret;
    int                   i;
    logic                 tx_en;
    spi_host_pkg::speed_e spd;
    seed_ret     = $urandom(12);
    sw_rst       = 1'b0;
    cmd_valid    = 1'b0;
    cmd_speed    = spi_host_pkg::Standard;
    cmd_len      = 8'h00;
    cmd_tx_en    = 1'b0;
    cmd_rx_en    = 1'b0;
    cmd_full_cyc = 1'b0;
    tx_data      = 8'h00;
    tx_valid     = 1'b0;
    rx_ready     = 1'b0;
    sd_in        = 4'h0;
    dev_busy     = 1'b0;
    dev_pos      = 0;
    rx_ready_pct = 70;

    @(negedge clk);
    check_idle("during reset");
    check_value(tx_ready, 1'b0, "tx_ready_o during reset");
    wait (rst_n);
    wait_drive_slot();
    check_idle("after reset");

    for (i = 0; i < NumStd; i++) begin
      run_command(spi_host_pkg::Standard, 8'($urandom_range(5, 0)), 1'b1, 1'b0, 1'b0, 3);
    end

    for (i = 0; i < NumRx; i++) begin
      spd = ($urandom_range(1, 0) == 1) ? spi_host_pkg::Quad : spi_host_pkg::Dual;
      run_command(spd, 8'($urandom_range(5, 0)), 1'b0, 1'b1, 1'($urandom_range(1, 0)), 3);
    end

    for (i = 0; i < NumDuplex; i++) begin
      spd = spi_host_pkg::speed_e'($urandom_range(3, 0));
      run_command(spd, 8'($urandom_range(5, 0)), 1'b1, 1'b1, 1'($urandom_range(1, 0)), 3);
    end

    // slow receiver and late transmit data force stalls
    rx_ready_pct = 20;
    for (i = 0; i < NumStress; i++) begin
      spd   = spi_host_pkg::speed_e'($urandom_range(3, 0));
      tx_en = 1'($urandom_range(1, 0));
      run_command(spd, 8'($urandom_range(7, 0)), tx_en, !tx_en || 1'($urandom_range(1, 0)),
                  1'($urandom_range(1, 0)), 40);
    end
    rx_ready_pct = 70;

    abort_with_sw_reset();
    run_command(spi_host_pkg::Quad, 8'd3, 1'b1, 1'b1, 1'b1, 3);

    $display("STATUS: PASS");
    $finish;
  end

endmodule
